/* hdl/dram_bridge_pkg.sv */
package dram_bridge_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int WORD_W      = 32;
  localparam int BLOCK_WORDS = 4;
  localparam int BLOCK_W     = WORD_W * BLOCK_WORDS;
  localparam int ADDR_W      = 32;
  localparam int WADDR_W     = ADDR_W - 2;
  localparam int TAG_W       = 4;
  localparam int NUM_IDS     = 8;
  localparam int ID_W        = 3;
  localparam int X_W         = 2;
  localparam int Y_W         = 1;
  localparam int EPA_W       = 28;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // block header, addr is block aligned
  typedef struct packed {
    mem_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [TAG_W-1:0]    tag;
  } mem_hdr_s;

  typedef struct packed {
    mem_op_e             op;
    logic [X_W-1:0]      x;
    logic [Y_W-1:0]      y;
    logic [EPA_W-1:0]    epa;
    logic [WORD_W-1:0]   data;
    logic [ID_W-1:0]     id;
  } net_req_s;

  typedef struct packed {
    logic [ID_W-1:0]     id;
    logic [WORD_W-1:0]   data;
  } net_rsp_s;

  // word address split for tile striping, word in the low bits
  typedef struct packed {
    logic [24:0]         row;
    logic [2:0]          tile;
    logic [1:0]          word;
  } dram_addr_fields_s;

  typedef union packed {
    logic [WADDR_W-1:0]  raw;
    dram_addr_fields_s   f;
  } dram_addr_u;

endpackage

/* hdl/beat_counter.sv */
`timescale 1ns/10ps

module beat_counter
  import dram_bridge_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       step_i,
  output logic [1:0] idx_o,
  output logic       first_o,
  output logic       last_o
);

  logic [1:0] idx_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      idx_q <= '0;
    end
    else if (step_i)
    begin
      // wrap back to word 0 after the last word of the block
      idx_q <= (idx_q == 2'(BLOCK_WORDS - 1)) ? 2'd0 : idx_q + 2'd1;
    end
  end

  assign idx_o   = idx_q;
  assign first_o = (idx_q == 2'd0);
  assign last_o  = (idx_q == 2'(BLOCK_WORDS - 1));

endmodule

/* hdl/req_pump.sv */
`timescale 1ns/10ps

module req_pump
  import dram_bridge_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_i,

  input  mem_hdr_s           fwd_hdr_i,
  input  logic [BLOCK_W-1:0] fwd_data_i,
  input  logic               fwd_v_i,
  output logic               fwd_ready_o,

  output dram_addr_u         word_addr_o,
  output logic [WORD_W-1:0]  word_data_o,
  output mem_op_e            word_op_o,
  output mem_hdr_s           word_hdr_o,
  output logic               word_v_o,
  input  logic               word_take_i
);

  typedef enum logic {
    ST_IDLE,
    ST_ISSUE
  } state_e;

  state_e             state_q;
  mem_hdr_s           hdr_q;
  logic [BLOCK_W-1:0] block_q;
  logic [1:0]         word_idx;
  logic               word_last;

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q <= ST_IDLE;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
          if (fwd_v_i)
            state_q <= ST_ISSUE;
        ST_ISSUE:
          if (word_take_i && word_last)
            state_q <= ST_IDLE;
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  // capture the block on acceptance
  always_ff @(posedge clk_i)
  begin
    if (fwd_v_i && fwd_ready_o)
    begin
      hdr_q   <= fwd_hdr_i;
      block_q <= fwd_data_i;
    end
  end

  beat_counter u_beat (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .step_i  (word_take_i),
    .idx_o   (word_idx),
    .first_o (),
    .last_o  (word_last)
  );

  // ----------------------------------------------------------
  // word presentation
  // ----------------------------------------------------------
  assign fwd_ready_o = (state_q == ST_IDLE);
  assign word_v_o    = (state_q == ST_ISSUE);
  assign word_op_o   = hdr_q.op;
  assign word_hdr_o  = hdr_q;
  assign word_data_o = block_q[word_idx*WORD_W +: WORD_W];

  // block address in words, plus the word index
  assign word_addr_o.raw = hdr_q.addr[ADDR_W-1:ADDR_W-WADDR_W] + WADDR_W'(word_idx);

endmodule

/* hdl/dram_hash.sv */
`timescale 1ns/10ps

module dram_hash
  import dram_bridge_pkg::*;
(
  input  dram_addr_u         addr_i,
  input  logic [WADDR_W-1:0] offset_i,
  output logic [X_W-1:0]     x_o,
  output logic [Y_W-1:0]     y_o,
  output logic [EPA_W-1:0]   epa_o
);

  dram_addr_u sum;

  always_comb
  begin
    sum.raw = addr_i.raw + offset_i;

    // consecutive blocks go to consecutive tiles
    // x from the low tile bits, y from the top one
    x_o = sum.f.tile[X_W-1:0];
    y_o = sum.f.tile[2 -: Y_W];

    // tile-local word address drops the tile bits
    epa_o = EPA_W'({sum.f.row, sum.f.word});
  end

endmodule

/* hdl/reorder_buf.sv */
`timescale 1ns/10ps

module reorder_buf
  import dram_bridge_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,

  output logic [ID_W-1:0]   alloc_id_o,
  output logic              alloc_v_o,
  input  logic              alloc_i,
  input  mem_hdr_s          alloc_hdr_i,

  input  net_rsp_s          rsp_i,
  input  logic              rsp_v_i,

  output logic [WORD_W-1:0] deq_data_o,
  output mem_hdr_s          deq_hdr_o,
  output logic              deq_v_o,
  input  logic              deq_i
);

  logic [ID_W-1:0]   alloc_ptr_q;
  logic [ID_W-1:0]   deq_ptr_q;
  logic [NUM_IDS-1:0] pending_q;
  logic [NUM_IDS-1:0] filled_q;
  logic [WORD_W-1:0] data_q [NUM_IDS];
  mem_hdr_s          hdr_q  [NUM_IDS];

  // ----------------------------------------------------------
  // slot state
  // ----------------------------------------------------------
  // alloc only hits a free slot, rsp only a pending one and deq only a
  // filled one, so the three updates never collide
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      alloc_ptr_q <= '0;
      deq_ptr_q   <= '0;
      pending_q   <= '0;
      filled_q    <= '0;
    end
    else
    begin
      if (alloc_i)
      begin
        pending_q[alloc_ptr_q] <= 1'b1;
        alloc_ptr_q            <= alloc_ptr_q + 1'b1;
      end
      if (rsp_v_i)
      begin
        pending_q[rsp_i.id] <= 1'b0;
        filled_q[rsp_i.id]  <= 1'b1;
      end
      if (deq_i)
      begin
        filled_q[deq_ptr_q] <= 1'b0;
        deq_ptr_q           <= deq_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (alloc_i)
      hdr_q[alloc_ptr_q] <= alloc_hdr_i;
    if (rsp_v_i)
      data_q[rsp_i.id] <= rsp_i.data;
  end

  // ids go out in order, so a busy slot at the pointer means full
  assign alloc_id_o = alloc_ptr_q;
  assign alloc_v_o  = ~pending_q[alloc_ptr_q] & ~filled_q[alloc_ptr_q];

  assign deq_v_o    = filled_q[deq_ptr_q];
  assign deq_data_o = data_q[deq_ptr_q];
  assign deq_hdr_o  = hdr_q[deq_ptr_q];

endmodule

/* hdl/rsp_pump.sv */
`timescale 1ns/10ps

module rsp_pump
  import dram_bridge_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_i,

  input  logic [WORD_W-1:0]  word_data_i,
  input  mem_hdr_s           word_hdr_i,
  input  logic               word_v_i,
  output logic               word_take_o,

  output mem_hdr_s           rev_hdr_o,
  output logic [BLOCK_W-1:0] rev_data_o,
  output logic               rev_v_o,
  input  logic               rev_ready_i
);

  logic [BLOCK_W-1:0] block_q;
  mem_hdr_s           hdr_q;
  logic               rev_v_q;
  logic               word_first;
  logic               word_last;

  // stall the reorder buffer while a finished block waits
  assign word_take_o = word_v_i & ~rev_v_q;

  beat_counter u_beat (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .step_i  (word_take_o),
    .idx_o   (),
    .first_o (word_first),
    .last_o  (word_last)
  );

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rev_v_q <= 1'b0;
    end
    else if (word_take_o && word_last)
    begin
      rev_v_q <= 1'b1;
    end
    else if (rev_ready_i)
    begin
      rev_v_q <= 1'b0;
    end
  end

  // shift in from the top so word 0 ends up in the low bits
  always_ff @(posedge clk_i)
  begin
    if (word_take_o)
    begin
      block_q <= {word_data_i, block_q[BLOCK_W-1:WORD_W]};
      if (word_first)
        hdr_q <= word_hdr_i;
    end
  end

  assign rev_v_o    = rev_v_q;
  assign rev_hdr_o  = hdr_q;
  assign rev_data_o = block_q;

endmodule

/* hdl/dram_bridge.sv */
`timescale 1ns/10ps

module dram_bridge
  import dram_bridge_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_i,

  input  mem_hdr_s           fwd_hdr_i,
  input  logic [BLOCK_W-1:0] fwd_data_i,
  input  logic               fwd_v_i,
  output logic               fwd_ready_o,

  output mem_hdr_s           rev_hdr_o,
  output logic [BLOCK_W-1:0] rev_data_o,
  output logic               rev_v_o,
  input  logic               rev_ready_i,

  output net_req_s           net_req_o,
  output logic               net_req_v_o,
  input  logic               net_req_ready_i,

  input  net_rsp_s           net_rsp_i,
  input  logic               net_rsp_v_i,

  input  logic [WADDR_W-1:0] dram_offset_i
);

  dram_addr_u          word_addr;
  logic [WORD_W-1:0]   word_data;
  mem_op_e             word_op;
  mem_hdr_s            word_hdr;
  logic                word_v;
  logic                word_take;

  logic [X_W-1:0]      tile_x;
  logic [Y_W-1:0]      tile_y;
  logic [EPA_W-1:0]    tile_epa;

  logic [ID_W-1:0]     alloc_id;
  logic                alloc_v;

  logic [WORD_W-1:0]   deq_data;
  mem_hdr_s            deq_hdr;
  logic                deq_v;
  logic                deq_take;

  // ----------------------------------------------------------
  // outgoing words
  // ----------------------------------------------------------
  req_pump u_req_pump (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fwd_hdr_i   (fwd_hdr_i),
    .fwd_data_i  (fwd_data_i),
    .fwd_v_i     (fwd_v_i),
    .fwd_ready_o (fwd_ready_o),
    .word_addr_o (word_addr),
    .word_data_o (word_data),
    .word_op_o   (word_op),
    .word_hdr_o  (word_hdr),
    .word_v_o    (word_v),
    .word_take_i (word_take)
  );

  dram_hash u_hash (
    .addr_i   (word_addr),
    .offset_i (dram_offset_i),
    .x_o      (tile_x),
    .y_o      (tile_y),
    .epa_o    (tile_epa)
  );

  // a word leaves only with a free id and a ready network
  assign word_take   = word_v & alloc_v & net_req_ready_i;
  assign net_req_v_o = word_take;

  always_comb
  begin
    net_req_o.op   = word_op;
    net_req_o.x    = tile_x;
    net_req_o.y    = tile_y;
    net_req_o.epa  = tile_epa;
    net_req_o.data = word_data;
    net_req_o.id   = alloc_id;
  end

  // ----------------------------------------------------------
  // returning words
  // ----------------------------------------------------------
  reorder_buf u_rob (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .alloc_id_o  (alloc_id),
    .alloc_v_o   (alloc_v),
    .alloc_i     (word_take),
    .alloc_hdr_i (word_hdr),
    .rsp_i       (net_rsp_i),
    .rsp_v_i     (net_rsp_v_i),
    .deq_data_o  (deq_data),
    .deq_hdr_o   (deq_hdr),
    .deq_v_o     (deq_v),
    .deq_i       (deq_take)
  );

  rsp_pump u_rsp_pump (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .word_data_i (deq_data),
    .word_hdr_i  (deq_hdr),
    .word_v_i    (deq_v),
    .word_take_o (deq_take),
    .rev_hdr_o   (rev_hdr_o),
    .rev_data_o  (rev_data_o),
    .rev_v_o     (rev_v_o),
    .rev_ready_i (rev_ready_i)
  );

endmodule

/* tests/dram_bridge_sva.sv */
`timescale 1ns/10ps

module dram_bridge_sva
  import dram_bridge_pkg::*;
(
  input logic               clk_i,
  input logic               rst_i,
  input mem_hdr_s           rev_hdr_o,
  input logic [BLOCK_W-1:0] rev_data_o,
  input logic               rev_v_o,
  input logic               rev_ready_i,
  input logic               net_req_v_o,
  input logic               net_req_ready_i
);

  // every net valid cycle is a transfer
  a_net_v_needs_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    net_req_v_o |-> net_req_ready_i)
    else $error("net_req_v_o high without net_req_ready_i");

  a_rev_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    rev_v_o && !rev_ready_i |=> rev_v_o && $stable(rev_hdr_o) && $stable(rev_data_o))
    else $error("reverse response changed before transfer");

  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> !net_req_v_o && !rev_v_o)
    else $error("valid raised during reset");

endmodule

bind dram_bridge dram_bridge_sva u_sva (.*);

/* tests/dram_bridge_checker.sv */
`timescale 1ns/10ps

module dram_bridge_checker
  import dram_bridge_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  mem_hdr_s           fwd_hdr_i,
  input  logic [BLOCK_W-1:0] fwd_data_i,
  input  logic               fwd_v_i,
  input  logic               fwd_ready_i,
  input  mem_hdr_s           rev_hdr_i,
  input  logic [BLOCK_W-1:0] rev_data_i,
  input  logic               rev_v_i,
  input  logic               rev_ready_i,
  input  net_req_s           net_req_i,
  input  logic               net_req_v_i,
  input  logic               net_rsp_v_i,
  input  logic [WADDR_W-1:0] dram_offset_i,
  output int                 errors_o,
  output int                 blocks_left_o
);

  typedef struct packed {
    mem_hdr_s           hdr;
    logic [BLOCK_W-1:0] data;
  } blk_s;

  net_req_s    exp_net_q[$];
  blk_s        exp_blk_q[$];
  logic [31:0] shadow [bit [WADDR_W-1:0]];
  int          outstanding;
  logic [ID_W-1:0] next_id;

  // unwritten tile words, every address bit feeds in
  function automatic logic [31:0] fill_pattern(input logic [30:0] key);
    return (32'(key) * 32'h9e3779b1) ^ 32'hc3a50f1e;
  endfunction

  initial
  begin
    errors_o      = 0;
    blocks_left_o = 0;
    outstanding   = 0;
  end

  always @(posedge clk_i)
  begin : watch
    net_req_s          exp_req;
    blk_s              exp_blk;
    logic [WADDR_W-1:0] waddr;
    logic [WADDR_W-1:0] sum;
    if (rst_i)
    begin
      outstanding = 0;
      next_id     = '0;
    end
    else
    begin
      // ----------------------------------------------------------
      // network side
      // ----------------------------------------------------------
      if (net_req_v_i)
      begin
        if (exp_net_q.size() == 0)
        begin
          $display("net request issued with no block accepted");
          errors_o++;
        end
        else
        begin
          // ids are handed out round robin from zero after reset
          exp_req = exp_net_q.pop_front();
          exp_req.id = next_id;
          if (exp_req != net_req_i)
          begin
            $display("Mismatch net_req_o: exp %h got %h", exp_req, net_req_i);
            errors_o++;
          end
        end
        next_id = next_id + 1'b1;
        outstanding++;
      end
      if (net_rsp_v_i)
        outstanding--;
      if (outstanding > NUM_IDS)
      begin
        $display("more than %0d net ids outstanding (%0d)", NUM_IDS, outstanding);
        errors_o++;
      end

      // ----------------------------------------------------------
      // block responses, in acceptance order
      // ----------------------------------------------------------
      if (rev_v_i && rev_ready_i)
      begin
        if (exp_blk_q.size() == 0)
        begin
          $display("block response with no request outstanding");
          errors_o++;
        end
        else
        begin
          exp_blk = exp_blk_q.pop_front();
          if (exp_blk.hdr != rev_hdr_i)
          begin
            $display("Mismatch rev_hdr_o: exp %h got %h", exp_blk.hdr, rev_hdr_i);
            errors_o++;
          end
          // write responses carry no defined data
          if (exp_blk.hdr.op == OP_READ && exp_blk.data != rev_data_i)
          begin
            $display("Mismatch rev_data_o: exp %h got %h", exp_blk.data, rev_data_i);
            errors_o++;
          end
        end
      end

      // predict the four words and the block on acceptance
      if (fwd_v_i && fwd_ready_i)
      begin
        exp_blk.hdr = fwd_hdr_i;
        for (int i = 0; i < BLOCK_WORDS; i++)
        begin
          waddr = fwd_hdr_i.addr[ADDR_W-1:2] + WADDR_W'(i);
          sum   = waddr + dram_offset_i;
          exp_req.op   = fwd_hdr_i.op;
          exp_req.x    = sum[3:2];
          exp_req.y    = sum[4];
          exp_req.epa  = EPA_W'({sum[29:5], sum[1:0]});
          exp_req.data = fwd_data_i[i*WORD_W +: WORD_W];
          exp_req.id   = '0;
          exp_net_q.push_back(exp_req);
          if (fwd_hdr_i.op == OP_WRITE)
            shadow[waddr] = exp_req.data;
          if (shadow.exists(waddr))
            exp_blk.data[i*WORD_W +: WORD_W] = shadow[waddr];
          else
            exp_blk.data[i*WORD_W +: WORD_W] =
              fill_pattern({exp_req.x, exp_req.y, exp_req.epa});
        end
        exp_blk_q.push_back(exp_blk);
      end
    end
    blocks_left_o = exp_blk_q.size();
  end

endmodule

/* tests/tb_dram_bridge.sv */
`timescale 1ns/10ps

module tb_dram_bridge
  import dram_bridge_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;

  logic               clk_i = 1'b0;
  logic               rst_i;
  mem_hdr_s           fwd_hdr_i;
  logic [BLOCK_W-1:0] fwd_data_i;
  logic               fwd_v_i;
  logic               fwd_ready_o;
  mem_hdr_s           rev_hdr_o;
  logic [BLOCK_W-1:0] rev_data_o;
  logic               rev_v_o;
  logic               rev_ready_i;
  net_req_s           net_req_o;
  logic               net_req_v_o;
  logic               net_req_ready_i;
  net_rsp_s           net_rsp_i;
  logic               net_rsp_v_i;
  logic [WADDR_W-1:0] dram_offset_i;

  int          seed = 32'he5b20255;
  int          errors;
  int          blocks_left;
  int          timeouts = 0;
  net_rsp_s    rsp_q[$];
  logic [31:0] tile_mem [bit [30:0]];
  logic [31:0] written_q[$];

  always #20 clk_i = ~clk_i;

  dram_bridge uut (.*);

  dram_bridge_checker chk (
    .clk_i, .rst_i, .fwd_hdr_i, .fwd_data_i, .fwd_v_i,
    .fwd_ready_i   (fwd_ready_o),
    .rev_hdr_i     (rev_hdr_o),
    .rev_data_i    (rev_data_o),
    .rev_v_i       (rev_v_o),
    .rev_ready_i,
    .net_req_i     (net_req_o),
    .net_req_v_i   (net_req_v_o),
    .net_rsp_v_i,
    .dram_offset_i,
    .errors_o      (errors),
    .blocks_left_o (blocks_left)
  );

  function automatic logic [31:0] fill_pattern(input logic [30:0] key);
    return (32'(key) * 32'h9e3779b1) ^ 32'hc3a50f1e;
  endfunction

  // ----------------------------------------------------------
  // DRAM tile model
  // ----------------------------------------------------------
  always @(posedge clk_i)
  begin : tile_accept
    logic [30:0] key;
    net_rsp_s    rsp;
    if (!rst_i && net_req_v_o)
    begin
      key     = {net_req_o.x, net_req_o.y, net_req_o.epa};
      rsp.id  = net_req_o.id;
      rsp.data = net_req_o.data;
      if (net_req_o.op == OP_WRITE)
        tile_mem[key] = net_req_o.data;
      else
        rsp.data = tile_mem.exists(key) ? tile_mem[key] : fill_pattern(key);
      rsp_q.push_back(rsp);
    end
  end

  // answers come back in random order, readies toggle randomly
  always @(negedge clk_i)
  begin : tile_answer
    int pick;
    net_req_ready_i = ($random(seed) & 3) != 0;
    rev_ready_i     = ($random(seed) & 3) != 0;
    net_rsp_v_i     = 1'b0;
    if (rsp_q.size() > 0 && $random(seed) % 2 == 0)
    begin
      pick        = {$random(seed)} % rsp_q.size();
      net_rsp_i   = rsp_q[pick];
      net_rsp_v_i = 1'b1;
      rsp_q.delete(pick);
    end
  end

  // called on a falling edge, returns on one
  task automatic send_block(input mem_hdr_s hdr, input logic [BLOCK_W-1:0] data);
    int cnt;
    cnt = 0;
    while (!fwd_ready_o && cnt < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      cnt++;
    end
    if (!fwd_ready_o)
    begin
      $display("timeout waiting for fwd_ready_o");
      timeouts++;
    end
    else
    begin
      fwd_hdr_i  = hdr;
      fwd_data_i = data;
      fwd_v_i    = 1'b1;
      @(negedge clk_i);
      fwd_v_i    = 1'b0;
    end
  endtask

  task automatic drain();
    int cnt;
    cnt = 0;
    while ((blocks_left != 0 || rsp_q.size() != 0) && cnt < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      cnt++;
    end
    if (blocks_left != 0)
    begin
      $display("timeout draining, %0d block responses missing", blocks_left);
      timeouts++;
    end
  endtask

  initial
  begin : stimulus
    mem_hdr_s hdr;
    rst_i           = 1'b1;
    fwd_hdr_i       = '0;
    fwd_data_i      = '0;
    fwd_v_i         = 1'b0;
    rev_ready_i     = 1'b0;
    net_req_ready_i = 1'b0;
    net_rsp_i       = '0;
    net_rsp_v_i     = 1'b0;
    dram_offset_i   = WADDR_W'($random(seed));
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // writes go low, reads go to a high region nobody writes
    for (int n = 0; n < 40; n++)
    begin
      hdr.tag = TAG_W'($random(seed));
      if ($random(seed) % 2 == 0)
      begin
        hdr.op   = OP_WRITE;
        hdr.addr = {24'h0, 4'($random(seed)), 4'h0};
        if (!(hdr.addr inside {written_q}))
          written_q.push_back(hdr.addr);
      end
      else
      begin
        hdr.op   = OP_READ;
        hdr.addr = {4'h8, 16'h0, 8'($random(seed)), 4'h0};
      end
      send_block(hdr, {$random(seed), $random(seed), $random(seed), $random(seed)});
    end
    drain();

    // read back every written block
    foreach (written_q[i])
    begin
      hdr.op   = OP_READ;
      hdr.addr = written_q[i];
      hdr.tag  = TAG_W'(i);
      send_block(hdr, '0);
    end
    drain();

    $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* flist.f */
hdl/dram_bridge_pkg.sv
hdl/beat_counter.sv
hdl/req_pump.sv
hdl/dram_hash.sv
hdl/reorder_buf.sv
hdl/rsp_pump.sv
hdl/dram_bridge.sv
tests/dram_bridge_sva.sv
tests/dram_bridge_checker.sv
tests/tb_dram_bridge.sv

/* run.sh */
#!/bin/sh
set -e

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dram_bridge -f flist.f
./obj_dir/Vtb_dram_bridge > sim.log 2>&1 || true
cat sim.log
grep -q "TEST RESULT: PASS" sim.log
